/* rtl/cpuCfg_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_XLEN     32
`define CPU_NREGS    32
`define CPU_RESET_PC 32'h0000_0000

// Major opcodes
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// SPECIAL function codes
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

`endif

/* rtl/isaPkg.sv */
package isaPkg;

    typedef logic [4:0] regAddr_t;

    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rs2;   // MIPS rt
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat_t;

    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm16;
    } iFormat_t;

    // One fetched word, seen as R-type or I-type
    typedef union packed {
        rFormat_t rFmt;
        iFormat_t iFmt;
    } instWord_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

endpackage

/* rtl/pipePkg.sv */
`include "cpuCfg_cfg.svh"

package pipePkg;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM
    } wbSrc_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } brKind_t;

    typedef struct packed {
        isaPkg::regAddr_t     rs;     // Zero when not read
        isaPkg::regAddr_t     rs2;
        isaPkg::regAddr_t     rd;     // Zero when nothing is written
        isaPkg::aluOp_t       aluOp;
        logic                 immSel;
        logic [`CPU_XLEN-1:0] imm;
        brKind_t              brKind;
        logic                 memLoad;
        logic                 memStore;
        wbSrc_t               wbSrc;
    } ctrlWord_t;

    localparam ctrlWord_t kCtrlNop = '{
        rs:       '0,
        rs2:      '0,
        rd:       '0,
        aluOp:    isaPkg::ALU_ADD,
        immSel:   1'b0,
        imm:      '0,
        brKind:   BR_NONE,
        memLoad:  1'b0,
        memStore: 1'b0,
        wbSrc:    WB_NONE
    };

endpackage

/* rtl/memBus.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

// One requester's strobe link to the arbiter
interface memBus;
    logic                 req;
    logic                 write;
    logic [`CPU_XLEN-1:0] addr;
    logic [`CPU_XLEN-1:0] wdata;
    logic [`CPU_XLEN-1:0] rdata;
    logic                 valid;   // Completion, also for writes

    modport requester (
        output req, write, addr, wdata,
        input  rdata, valid
    );

    modport arbiter (
        input  req, write, addr, wdata,
        output rdata, valid
    );
endinterface

/* rtl/fetchUnit.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module fetchUnit (
    input  logic                 clk,
    input  logic                 reset,
    memBus.requester             bus,
    input  logic                 redirect,
    input  logic [`CPU_XLEN-1:0] redirectPc,
    input  logic                 take,
    output logic                 instValid,
    output isaPkg::instWord_t    inst,
    output logic [`CPU_XLEN-1:0] instPc
);
    logic [`CPU_XLEN-1:0] pc;       // Next address to fetch
    logic [`CPU_XLEN-1:0] pendPc;
    logic [`CPU_XLEN-1:0] nextPc;
    logic                 pending;
    logic                 stale;    // Outstanding response belongs to a flushed path
    logic                 started;  // Low until one edge has passed out of reset
    logic                 issue;

    assign nextPc = redirect ? redirectPc : pc;
    assign issue  = started && !pending && (!instValid || take || redirect);

    assign bus.req   = issue;
    assign bus.write = 1'b0;
    assign bus.addr  = nextPc;
    assign bus.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= `CPU_RESET_PC;
            pending   <= 1'b0;
            stale     <= 1'b0;
            started   <= 1'b0;
            instValid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (issue) begin
                pc <= nextPc + 4;
            end else if (redirect) begin
                pc <= redirectPc;
            end
            pending <= issue || (pending && !bus.valid);
            stale   <= pending && !bus.valid && (stale || redirect);
            if (bus.valid && !stale && !redirect) begin
                instValid <= 1'b1;
            end else if (take || redirect) begin
                instValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pendPc <= nextPc;
        end
        if (bus.valid) begin
            inst   <= bus.rdata;
            instPc <= pendPc;
        end
    end
endmodule

/* rtl/instDecoder.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module instDecoder (
    input  isaPkg::instWord_t  inst,
    output pipePkg::ctrlWord_t ctrl
);
    import isaPkg::*;
    import pipePkg::*;

    logic [`CPU_XLEN-1:0] sImm;
    logic [`CPU_XLEN-1:0] zImm;

    assign sImm = {{(`CPU_XLEN-16){inst.iFmt.imm16[15]}}, inst.iFmt.imm16};
    assign zImm = {{(`CPU_XLEN-16){1'b0}}, inst.iFmt.imm16};

    always_comb begin
        ctrl = kCtrlNop;
        case (inst.rFmt.opcode)
            `OP_SPECIAL: begin
                ctrl.rs    = inst.rFmt.rs;
                ctrl.rs2   = inst.rFmt.rs2;
                ctrl.rd    = inst.rFmt.rd;
                ctrl.wbSrc = WB_ALU;
                case (inst.rFmt.funct)
                    `FN_ADDU: ctrl.aluOp = ALU_ADD;
                    `FN_SUBU: ctrl.aluOp = ALU_SUB;
                    `FN_AND:  ctrl.aluOp = ALU_AND;
                    `FN_OR:   ctrl.aluOp = ALU_OR;
                    `FN_XOR:  ctrl.aluOp = ALU_XOR;
                    `FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default:  ctrl = kCtrlNop;
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI, `OP_LW: begin
                ctrl.rs     = inst.iFmt.rs;
                ctrl.rd     = inst.iFmt.rt;   // I-type writes rt
                ctrl.immSel = 1'b1;
                ctrl.imm    = sImm;
                ctrl.wbSrc  = WB_ALU;
                if (inst.iFmt.opcode == `OP_ORI) begin
                    ctrl.aluOp = ALU_OR;
                    ctrl.imm   = zImm;
                end else if (inst.iFmt.opcode == `OP_LUI) begin
                    ctrl.rs    = '0;
                    ctrl.aluOp = ALU_LUI;
                    ctrl.imm   = zImm;
                end else if (inst.iFmt.opcode == `OP_LW) begin
                    ctrl.memLoad = 1'b1;
                    ctrl.wbSrc   = WB_MEM;
                end
            end
            `OP_SW: begin
                ctrl.rs       = inst.iFmt.rs;
                ctrl.rs2      = inst.iFmt.rt;
                ctrl.immSel   = 1'b1;
                ctrl.imm      = sImm;
                ctrl.memStore = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                ctrl.rs     = inst.iFmt.rs;
                ctrl.rs2    = inst.iFmt.rt;
                ctrl.imm    = sImm;
                ctrl.brKind = (inst.iFmt.opcode == `OP_BEQ) ? BR_EQ : BR_NE;
            end
            `OP_J: begin
                ctrl.imm    = {6'b0, inst.iFmt.rs, inst.iFmt.rt, inst.iFmt.imm16};
                ctrl.brKind = BR_JUMP;
            end
            default: ;
        endcase
    end
endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module decodeStage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instValid,
    input  isaPkg::instWord_t    inst,
    input  logic [`CPU_XLEN-1:0] instPc,
    output logic                 take,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] redirectPc,
    input  logic                 accessBusy,
    input  isaPkg::regAddr_t     accessDest,
    input  logic                 accessIsLoad,
    input  logic [`CPU_XLEN-1:0] accessValue,
    input  logic                 retireWe,
    input  isaPkg::regAddr_t     retireReg,
    input  logic [`CPU_XLEN-1:0] retireData,
    output logic                 outValid,
    output pipePkg::ctrlWord_t   outCtrl,
    output logic [`CPU_XLEN-1:0] outPc,
    output logic [`CPU_XLEN-1:0] outResult,
    output logic [`CPU_XLEN-1:0] outStoreData
);
    import isaPkg::*;
    import pipePkg::*;

    ctrlWord_t            ctrl;
    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
    logic [`CPU_XLEN-1:0] srcA;
    logic [`CPU_XLEN-1:0] srcB;
    logic [`CPU_XLEN-1:0] opB;
    logic [`CPU_XLEN-1:0] result;
    logic [`CPU_XLEN-1:0] target;
    logic                 taken;
    logic                 loadUse;

    instDecoder u_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    // Youngest producer wins
    function automatic logic [`CPU_XLEN-1:0] readReg(regAddr_t r);
        if (r == '0) begin
            return '0;
        end
        if (r == accessDest && !accessIsLoad) begin
            return accessValue;
        end
        if (retireWe && r == retireReg) begin
            return retireData;
        end
        return regs[r];
    endfunction

    always_comb begin
        srcA = readReg(ctrl.rs);
        srcB = readReg(ctrl.rs2);
    end

    assign loadUse  = accessIsLoad && accessDest != '0
                    && (ctrl.rs == accessDest || ctrl.rs2 == accessDest);
    assign take     = instValid && !accessBusy && !loadUse;
    assign opB      = ctrl.immSel ? ctrl.imm : srcB;

    always_comb begin
        case (ctrl.aluOp)
            ALU_SUB: result = srcA - opB;
            ALU_AND: result = srcA & opB;
            ALU_OR:  result = srcA | opB;
            ALU_XOR: result = srcA ^ opB;
            ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, $signed(srcA) < $signed(opB)};
            ALU_LUI: result = opB << 16;
            default: result = srcA + opB;   // Also the load/store address
        endcase
    end

    always_comb begin
        case (ctrl.brKind)
            BR_EQ:   taken = srcA == srcB;
            BR_NE:   taken = srcA != srcB;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        if (ctrl.brKind == BR_JUMP) begin
            target = {instPc[`CPU_XLEN-1 -: 4], ctrl.imm[25:0], 2'b00};
        end else begin
            target = instPc + 4 + (ctrl.imm << 2);
        end
    end

    assign redirect   = take && taken;
    assign redirectPc = target;

    always_ff @(posedge clk) begin
        if (retireWe && retireReg != '0) begin
            regs[retireReg] <= retireData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            outCtrl  <= kCtrlNop;
        end else if (!accessBusy) begin
            outValid <= take;
            outCtrl  <= take ? ctrl : kCtrlNop;   // Bubble on stall
        end
    end

    always_ff @(posedge clk) begin
        if (!accessBusy) begin
            outPc        <= instPc;
            outResult    <= result;
            outStoreData <= srcB;
        end
    end
endmodule

/* rtl/accessStage.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module accessStage (
    input  logic                 clk,
    input  logic                 reset,
    memBus.requester             bus,
    input  logic                 inValid,
    input  pipePkg::ctrlWord_t   inCtrl,
    input  logic [`CPU_XLEN-1:0] inPc,
    input  logic [`CPU_XLEN-1:0] inResult,
    input  logic [`CPU_XLEN-1:0] inStoreData,
    output logic                 busy,
    output isaPkg::regAddr_t     fwdDest,
    output logic                 fwdIsLoad,
    output logic [`CPU_XLEN-1:0] fwdValue,
    output logic                 retireWe,
    output logic                 retireValid,
    output isaPkg::regAddr_t     retireReg,
    output logic [`CPU_XLEN-1:0] retirePc,
    output logic [`CPU_XLEN-1:0] retireData
);
    import pipePkg::*;

    logic isMem;
    logic issued;   // Request for the current instruction already sent

    assign isMem = inValid && (inCtrl.memLoad || inCtrl.memStore);
    assign busy  = isMem && !bus.valid;

    assign bus.req   = isMem && !issued;
    assign bus.write = inCtrl.memStore;
    assign bus.addr  = inResult;
    assign bus.wdata = inStoreData;

    assign fwdDest   = inCtrl.rd;
    assign fwdIsLoad = inCtrl.memLoad;
    assign fwdValue  = inResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            issued      <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            if (bus.valid) begin
                issued <= 1'b0;
            end else if (bus.req) begin
                issued <= 1'b1;
            end
            retireValid <= inValid && !busy;
        end
    end

    always_ff @(posedge clk) begin
        retirePc   <= inPc;
        retireReg  <= inCtrl.rd;
        retireData <= (inCtrl.wbSrc == WB_MEM) ? bus.rdata : inResult;
    end

    assign retireWe = retireValid && retireReg != '0;
endmodule

/* rtl/busArbiter.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module busArbiter (
    input  logic                 clk,
    input  logic                 reset,
    memBus.arbiter               fetchBus,
    memBus.arbiter               accessBus,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [`CPU_XLEN-1:0] memAddr,
    output logic [`CPU_XLEN-1:0] memWdata,
    input  logic [`CPU_XLEN-1:0] memRdata,
    input  logic                 memValid
);
    // Slot 0 fetch, slot 1 access
    logic [1:0]           slotValid;
    logic [1:0]           slotWrite;
    logic [`CPU_XLEN-1:0] slotAddr  [2];
    logic [`CPU_XLEN-1:0] slotWdata [2];
    logic                 busy;
    logic                 owner;
    logic                 grant;

    assign grant    = slotValid[1];   // Access has priority
    assign memReq   = !busy && (slotValid != 2'b00);
    assign memWrite = memReq && slotWrite[grant];
    assign memAddr  = slotAddr[grant];
    assign memWdata = slotWdata[grant];

    assign fetchBus.rdata  = memRdata;
    assign accessBus.rdata = memRdata;
    assign fetchBus.valid  = memValid && busy && !owner;
    assign accessBus.valid = memValid && busy && owner;

    always_ff @(posedge clk) begin
        if (reset) begin
            slotValid <= 2'b00;
            busy      <= 1'b0;
            owner     <= 1'b0;
        end else begin
            if (memReq) begin
                slotValid[grant] <= 1'b0;
                busy             <= 1'b1;
                owner            <= grant;
            end else if (memValid) begin
                busy <= 1'b0;
            end
            if (fetchBus.req) begin
                slotValid[0] <= 1'b1;
            end
            if (accessBus.req) begin
                slotValid[1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchBus.req) begin
            slotWrite[0] <= fetchBus.write;
            slotAddr[0]  <= fetchBus.addr;
            slotWdata[0] <= fetchBus.wdata;
        end
        if (accessBus.req) begin
            slotWrite[1] <= accessBus.write;
            slotAddr[1]  <= accessBus.addr;
            slotWdata[1] <= accessBus.wdata;
        end
    end
endmodule

/* rtl/pipelineCpu.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module pipelineCpu (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [`CPU_XLEN-1:0] memAddr,
    output logic [`CPU_XLEN-1:0] memWdata,
    input  logic [`CPU_XLEN-1:0] memRdata,
    input  logic                 memValid,
    output logic                 retireValid,
    output logic [`CPU_XLEN-1:0] retirePc,
    output isaPkg::regAddr_t     retireReg,
    output logic [`CPU_XLEN-1:0] retireData
);
    import isaPkg::*;
    import pipePkg::*;

    memBus fetchBus ();
    memBus accessBus ();

    instWord_t            inst;
    logic                 instValid;
    logic [`CPU_XLEN-1:0] instPc;
    logic                 take;
    logic                 redirect;
    logic [`CPU_XLEN-1:0] redirectPc;
    logic                 dValid;
    ctrlWord_t            dCtrl;
    logic [`CPU_XLEN-1:0] dPc;
    logic [`CPU_XLEN-1:0] dResult;
    logic [`CPU_XLEN-1:0] dStoreData;
    logic                 accessBusy;
    regAddr_t             fwdDest;
    logic                 fwdIsLoad;
    logic [`CPU_XLEN-1:0] fwdValue;
    logic                 retireWe;

    fetchUnit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .bus        (fetchBus.requester),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .take       (take),
        .instValid  (instValid),
        .inst       (inst),
        .instPc     (instPc)
    );

    decodeStage u_decode (
        .clk          (clk),
        .reset        (reset),
        .instValid    (instValid),
        .inst         (inst),
        .instPc       (instPc),
        .take         (take),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .accessBusy   (accessBusy),
        .accessDest   (fwdDest),
        .accessIsLoad (fwdIsLoad),
        .accessValue  (fwdValue),
        .retireWe     (retireWe),
        .retireReg    (retireReg),
        .retireData   (retireData),
        .outValid     (dValid),
        .outCtrl      (dCtrl),
        .outPc        (dPc),
        .outResult    (dResult),
        .outStoreData (dStoreData)
    );

    accessStage u_access (
        .clk         (clk),
        .reset       (reset),
        .bus         (accessBus.requester),
        .inValid     (dValid),
        .inCtrl      (dCtrl),
        .inPc        (dPc),
        .inResult    (dResult),
        .inStoreData (dStoreData),
        .busy        (accessBusy),
        .fwdDest     (fwdDest),
        .fwdIsLoad   (fwdIsLoad),
        .fwdValue    (fwdValue),
        .retireWe    (retireWe),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retirePc    (retirePc),
        .retireData  (retireData)
    );

    busArbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .fetchBus  (fetchBus.arbiter),
        .accessBus (accessBus.arbiter),
        .memReq    (memReq),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memRdata  (memRdata),
        .memValid  (memValid)
    );
endmodule

/* sim/tbMemory.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module tbMemory #(
    parameter int memWords = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 memReq,
    input  logic                 memWrite,
    input  logic [`CPU_XLEN-1:0] memAddr,
    input  logic [`CPU_XLEN-1:0] memWdata,
    output logic [`CPU_XLEN-1:0] memRdata,
    output logic                 memValid
);
    logic [`CPU_XLEN-1:0] mem [memWords];
    logic [`CPU_XLEN-1:0] rng;
    logic [`CPU_XLEN-1:0] reqAddr;
    logic [`CPU_XLEN-1:0] reqWdata;
    logic                 reqWrite;
    int                   waitCnt;   // Cycles left on the request in service
    int                   loadAt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int wordIndex(input logic [`CPU_XLEN-1:0] addr);
        return int'((addr >> 2) % memWords);
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [25:0] index);
        return {`OP_J, index};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[loadAt] = word;
        loadAt++;
    endtask

    task automatic loadPrograms();
        loadAt = 0;
        // ALU and immediates
        emit(iType(`OP_LUI, 1, 0, 16'h1234));
        emit(iType(`OP_ORI, 1, 1, 16'h5678));
        emit(iType(`OP_ADDIU, 2, 0, 16'hfffb));
        emit(iType(`OP_ADDIU, 3, 0, 16'd100));
        emit(rType(`FN_ADDU, 4, 1, 3));
        emit(rType(`FN_SUBU, 5, 3, 2));
        emit(rType(`FN_AND, 6, 1, 2));
        emit(rType(`FN_OR, 7, 3, 2));
        emit(rType(`FN_XOR, 8, 1, 4));
        emit(rType(`FN_SLT, 9, 2, 3));
        emit(rType(`FN_SLT, 10, 3, 2));
        emit(rType(`FN_ADDU, 0, 1, 1));         // r0 stays zero
        // Dependent chains, word 12
        emit(iType(`OP_ADDIU, 11, 0, 16'd7));
        emit(rType(`FN_ADDU, 12, 11, 11));
        emit(rType(`FN_ADDU, 13, 12, 11));
        emit(rType(`FN_SUBU, 14, 13, 12));
        emit(rType(`FN_XOR, 15, 14, 13));
        // Loads and stores around 0x200, word 17
        emit(iType(`OP_ADDIU, 20, 0, 16'h0200));
        emit(iType(`OP_SW, 4, 20, 16'd0));
        emit(iType(`OP_LW, 21, 20, 16'd0));
        emit(rType(`FN_ADDU, 22, 21, 21));      // Load-use
        emit(iType(`OP_LW, 23, 20, 16'd8));
        emit(iType(`OP_SW, 23, 20, 16'd4));
        emit(iType(`OP_LW, 24, 20, 16'd4));
        emit(rType(`FN_SUBU, 25, 24, 23));
        emit(iType(`OP_SW, 25, 20, 16'hfffc));
        // Branches, word 26
        emit(iType(`OP_BEQ, 3, 3, 16'd2));      // Taken
        emit(iType(`OP_ADDIU, 26, 0, 16'd1));
        emit(iType(`OP_ADDIU, 26, 0, 16'd2));
        emit(iType(`OP_BNE, 3, 3, 16'd5));
        emit(iType(`OP_BEQ, 2, 1, 16'd5));
        emit(iType(`OP_BNE, 2, 1, 16'd1));      // Taken
        emit(iType(`OP_ADDIU, 27, 0, 16'd3));
        emit(jType(26'd36));
        emit(iType(`OP_ADDIU, 27, 0, 16'd4));
        emit(iType(`OP_ADDIU, 27, 0, 16'd5));
        emit(iType(`OP_ADDIU, 27, 0, 16'd9));
        // Load, add, store loop, word 37
        emit(iType(`OP_ADDIU, 28, 0, 16'd4));
        emit(iType(`OP_ADDIU, 29, 20, 16'd16));
        emit(iType(`OP_LW, 30, 29, 16'd0));
        emit(rType(`FN_ADDU, 30, 30, 28));
        emit(iType(`OP_SW, 30, 29, 16'd0));
        emit(iType(`OP_ADDIU, 29, 29, 16'd4));
        emit(iType(`OP_ADDIU, 28, 28, 16'hffff));
        emit(iType(`OP_BNE, 0, 28, 16'hfffa));
        emit(iType(`OP_LW, 31, 20, 16'd16));
        emit(jType(26'd46));                    // Halt loop
    endtask

    initial begin
        memValid = 1'b0;
        memRdata = '0;
        waitCnt  = 0;
        rng      = 32'hacc6;
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'hda7a_0000 ^ (32'(i) << 2);
        end
        loadPrograms();
        forever begin
            @(negedge clk);
            memValid <= 1'b0;
            if (reset) begin
                waitCnt = 0;
            end else begin
                if (waitCnt > 0) begin
                    waitCnt--;
                    if (waitCnt == 0) begin
                        if (reqWrite) begin
                            mem[wordIndex(reqAddr)] = reqWdata;
                        end
                        memRdata <= mem[wordIndex(reqAddr)];
                        memValid <= 1'b1;
                    end
                end
                if (memReq) begin
                    reqAddr  = memAddr;
                    reqWdata = memWdata;
                    reqWrite = memWrite;
                    rng      = xorshift32(rng);
                    waitCnt  = 1 + int'(rng % 3);   // 1 to 3 cycles
                end
            end
        end
    end
endmodule

/* sim/tbCpu.sv */
`timescale 1ns/1ps
`include "cpuCfg_cfg.svh"

module tbCpu;
    import isaPkg::*;

    localparam int memWords        = 256;
    localparam int cyclesPerRetire = 400;

    logic                 clk;
    logic                 reset;
    logic                 memReq;
    logic                 memWrite;
    logic [`CPU_XLEN-1:0] memAddr;
    logic [`CPU_XLEN-1:0] memWdata;
    logic [`CPU_XLEN-1:0] memRdata;
    logic                 memValid;
    logic                 retireValid;
    logic [`CPU_XLEN-1:0] retirePc;
    regAddr_t             retireReg;
    logic [`CPU_XLEN-1:0] retireData;

    // Reference ISA model
    logic [`CPU_XLEN-1:0] modelRegs [`CPU_NREGS];
    logic [`CPU_XLEN-1:0] modelMem  [memWords];
    logic [`CPU_XLEN-1:0] modelPc;
    logic                 modelHalt;
    logic [`CPU_XLEN-1:0] expPc;
    regAddr_t             expReg;
    logic [`CPU_XLEN-1:0] expData;
    int                   expectedCount;
    int                   retired;
    logic                 outstanding;
    logic                 seenReq;

    pipelineCpu i_dut (
        .clk         (clk),
        .reset       (reset),
        .memReq      (memReq),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .memRdata    (memRdata),
        .memValid    (memValid),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

    tbMemory #(.memWords(memWords)) i_mem (
        .clk      (clk),
        .reset    (reset),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .memValid (memValid)
    );

    always #50 clk = ~clk;

    task automatic failWithMessage(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            failWithMessage($sformatf("[ERROR] %s: %s expected %h, actual %h",
                                      test, what, exp, act));
        end
    endtask

    task automatic checkQuietPorts(input string test);
        checkValue(test, "memReq", 32'd0, {31'b0, memReq});
        checkValue(test, "memWrite", 32'd0, {31'b0, memWrite});
        checkValue(test, "retireValid", 32'd0, {31'b0, retireValid});
    endtask

    function automatic int memIndex(input logic [`CPU_XLEN-1:0] addr);
        return int'((addr >> 2) % memWords);
    endfunction

    // Section starts in words: 12, 17, 26, 37
    function automatic string sectionName(input logic [`CPU_XLEN-1:0] pc);
        if (pc < 32'd48) return "alu";
        if (pc < 32'd68) return "forwarding";
        if (pc < 32'd104) return "load/store";
        if (pc < 32'd148) return "branch";
        return "arbitration";
    endfunction

    task automatic resetModel();
        for (int i = 0; i < `CPU_NREGS; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < memWords; i++) begin
            modelMem[i] = i_mem.mem[i];
        end
        modelPc = `CPU_RESET_PC;
    endtask

    // Executes one instruction and leaves the expected trace in expPc/expReg/expData
    task automatic stepModel();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] next;
        w         = modelMem[memIndex(modelPc)];
        a         = modelRegs[w[25:21]];
        b         = modelRegs[w[20:16]];
        se        = {{16{w[15]}}, w[15:0]};
        next      = modelPc + 4;
        expPc     = modelPc;
        expReg    = '0;
        expData   = '0;
        modelHalt = 1'b0;
        case (w[31:26])
            `OP_SPECIAL: begin
                expReg = w[15:11];
                case (w[5:0])
                    `FN_ADDU: expData = a + b;
                    `FN_SUBU: expData = a - b;
                    `FN_AND:  expData = a & b;
                    `FN_OR:   expData = a | b;
                    `FN_XOR:  expData = a ^ b;
                    `FN_SLT:  expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  failWithMessage("Program holds an unknown function code");
                endcase
            end
            `OP_ADDIU: begin
                expReg  = w[20:16];
                expData = a + se;
            end
            `OP_ORI: begin
                expReg  = w[20:16];
                expData = a | {16'h0, w[15:0]};
            end
            `OP_LUI: begin
                expReg  = w[20:16];
                expData = {w[15:0], 16'h0};
            end
            `OP_LW: begin
                expReg  = w[20:16];
                expData = modelMem[memIndex(a + se)];
            end
            `OP_SW:  modelMem[memIndex(a + se)] = b;
            `OP_BEQ: next = (a == b) ? modelPc + 4 + (se << 2) : next;
            `OP_BNE: next = (a != b) ? modelPc + 4 + (se << 2) : next;
            `OP_J: begin
                next      = {modelPc[31:28], w[25:0], 2'b00};
                modelHalt = next == modelPc;
            end
            default: failWithMessage("Program holds an unknown opcode");
        endcase
        if (expReg != '0) begin
            modelRegs[expReg] = expData;
        end
        modelPc = next;
    endtask

    // Port-level request rule and first fetch address
    always @(negedge clk) begin
        if (reset) begin
            outstanding = 1'b0;
            seenReq     = 1'b0;
        end else begin
            if (memValid) begin
                outstanding = 1'b0;   // Response taken at the last edge
            end
            if (memReq === 1'b1) begin
                assert (!outstanding) else begin
                    failWithMessage("memReq rose again while a response was outstanding");
                end
                if (!seenReq) begin
                    checkValue("reset", "first fetch address", `CPU_RESET_PC, memAddr);
                    checkValue("reset", "first request write", 32'd0, {31'b0, memWrite});
                end
                seenReq     = 1'b1;
                outstanding = 1'b1;
            end
        end
    end

    initial begin
        wait (expectedCount != 0);
        repeat (cyclesPerRetire * expectedCount) @(posedge clk);
        failWithMessage("Watchdog expired before the program finished retiring");
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        expectedCount = 0;
        retired       = 0;
        @(negedge clk);
        resetModel();
        modelHalt = 1'b0;
        while (!modelHalt && expectedCount < 10000) begin
            stepModel();
            expectedCount++;
        end
        if (!modelHalt) begin
            failWithMessage("Reference model never reached the halt loop");
        end
        resetModel();
        checkQuietPorts("reset");
        repeat (4) begin
            @(negedge clk);
            checkQuietPorts("reset");
        end
        reset <= 1'b0;
        @(negedge clk);
        checkQuietPorts("after reset");
        while (retired < expectedCount) begin
            @(negedge clk);
            if (retireValid === 1'b1) begin
                stepModel();
                checkValue(sectionName(expPc), "retire pc", expPc, retirePc);
                checkValue(sectionName(expPc), "retire reg", {27'b0, expReg}, {27'b0, retireReg});
                if (expReg != '0) begin
                    checkValue(sectionName(expPc), "retire data", expData, retireData);
                end
                retired++;
            end
        end
        for (int i = 0; i < memWords; i++) begin
            checkValue("memory", $sformatf("word %0d", i), modelMem[i], i_mem.mem[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end
endmodule

/* all.f */
+incdir+rtl
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/memBus.sv
rtl/fetchUnit.sv
rtl/instDecoder.sv
rtl/decodeStage.sv
rtl/accessStage.sv
rtl/busArbiter.sv
rtl/pipelineCpu.sv
sim/tbMemory.sv
sim/tbCpu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timing --top-module tbCpu -f all.f -o simCpu &&
./obj_dir/simCpu || exit 1
